// File: source/stream_ops_pkg.sv
package stream_ops_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int num_lanes        = 4;
  localparam int streams_per_lane = 2;
  localparam int pe_id_w          = 6;
  localparam int stream_code_w    = 2;
  localparam int stream_count_w   = 2;

  typedef logic [pe_id_w-1:0]        pe_id_t;
  typedef logic [31:0]               op_word_t;
  typedef logic [num_lanes-1:0]      lane_mask_t;
  typedef logic [stream_code_w-1:0]  stream_code_t;
  // 0, 1 or 2 streams
  typedef logic [stream_count_w-1:0] stream_count_t;

  // ----------------------------------------
  // rs0 field positions (lsb of each field)
  // ----------------------------------------
  localparam int enable_bit     = 0;
  localparam int src_count_lsb  = 1;
  localparam int dest_count_lsb = 3;
  localparam int strm0_src_lsb  = 5;
  localparam int strm1_src_lsb  = 7;
  localparam int strm0_dest_lsb = 9;
  localparam int strm1_dest_lsb = 11;

  // stream source/dest code for local memory
  localparam stream_code_t code_memory = 2'd1;

  // main controller states
  typedef enum logic [2:0] {
    mem_wait, mem_request_state, mem_granted_state, op_run, mem_release, op_complete
  } mem_state_t;

  // per-lane stream controller states
  typedef enum logic [2:0] {
    lane_wait, lane_dma_write, lane_enable_stop, lane_dma_read, lane_run,
    lane_wait_sync, lane_complete
  } lane_state_t;

endpackage

// File: source/stream_op_if.sv
`timescale 1ns/100ps

interface stream_op_if;
  import stream_ops_pkg::*;

  // decoded operation fields
  logic                                op_enable;
  lane_mask_t                          lane_active;
  stream_count_t                       src_count;
  stream_count_t                       dest_count;
  stream_count_t                       from_memory_count;
  stream_count_t                       to_memory_count;
  stream_code_t [streams_per_lane-1:0] stream_source;
  stream_code_t [streams_per_lane-1:0] stream_dest;

  // memory granted, lanes may run
  logic                                strm_enable;
  // one bit driven by each lane
  wire lane_mask_t                     lane_synced;
  wire lane_mask_t                     lane_done;

  modport decoder (
    output op_enable, lane_active, src_count, dest_count,
    output from_memory_count, to_memory_count, stream_source, stream_dest
  );

  modport sequencer (
    input  op_enable,
    output strm_enable,
    input  lane_synced, lane_done
  );

  modport lane (
    input  op_enable, lane_active, src_count, dest_count,
    input  from_memory_count, to_memory_count, stream_source, stream_dest,
    input  strm_enable,
    output lane_synced, lane_done
  );

endinterface

// File: source/op_decode.sv
`timescale 1ns/100ps

module op_decode (
  input stream_ops_pkg::op_word_t rs0,
  input stream_ops_pkg::op_word_t rs1,
  stream_op_if.decoder            op
);
  import stream_ops_pkg::*;

  stream_code_t [streams_per_lane-1:0] src_codes;
  stream_code_t [streams_per_lane-1:0] dest_codes;
  stream_count_t                       from_mem;
  stream_count_t                       to_mem;

  // ----------------------------------------
  // field extraction
  // ----------------------------------------
  assign op.op_enable   = rs0[enable_bit];
  // one lane mask bit per exec lane, lsb aligned
  assign op.lane_active = rs1[num_lanes-1:0];
  assign op.src_count   = rs0[src_count_lsb +: stream_count_w];
  assign op.dest_count  = rs0[dest_count_lsb +: stream_count_w];

  assign src_codes[0]  = rs0[strm0_src_lsb +: stream_code_w];
  assign src_codes[1]  = rs0[strm1_src_lsb +: stream_code_w];
  assign dest_codes[0] = rs0[strm0_dest_lsb +: stream_code_w];
  assign dest_codes[1] = rs0[strm1_dest_lsb +: stream_code_w];

  assign op.stream_source = src_codes;
  assign op.stream_dest   = dest_codes;

  // ----------------------------------------
  // count streams from/to local memory
  // ----------------------------------------
  always_comb
  begin
    from_mem = '0;
    to_mem   = '0;
    for (int s = 0; s < streams_per_lane; s++)
    begin
      if (src_codes[s] == code_memory)
        from_mem = from_mem + 1'b1;
      if (dest_codes[s] == code_memory)
        to_mem = to_mem + 1'b1;
    end
  end

  assign op.from_memory_count = from_mem;
  assign op.to_memory_count   = to_mem;

endmodule

// File: source/mem_sequencer.sv
`timescale 1ns/100ps

module mem_sequencer (
  input  logic           clk,
  input  logic           reset,
  stream_op_if.sequencer op,
  input  logic           mem_granted,
  output logic           mem_request,
  output logic           mem_released,
  output logic           ready,
  output logic           complete,
  output logic           this_synchronized
);
  import stream_ops_pkg::*;

  mem_state_t state;
  mem_state_t state_next;

  logic lanes_done;
  logic lanes_synced;
  logic mem_request_next;
  logic mem_released_next;
  logic set_run;
  logic clear_op;

  // inactive lanes already report done/synced
  assign lanes_done   = &op.lane_done;
  assign lanes_synced = &op.lane_synced;

  // ----------------------------------------
  // memory request FSM
  // ----------------------------------------
  always_comb
  begin
    state_next = state;
    case (state)
      mem_wait:
        if (op.op_enable)
          state_next = mem_request_state;
      mem_request_state:
        if (!op.op_enable)
          state_next = mem_release;
        else if (mem_granted)
          state_next = mem_granted_state;
      mem_granted_state:
        state_next = op.op_enable ? op_run : mem_release;
      // lanes run here until all finish or enable drops
      op_run:
        if (!op.op_enable || lanes_done)
          state_next = mem_release;
      mem_release:
        if (!mem_granted)
          state_next = op_complete;
      op_complete:
        if (!op.op_enable)
          state_next = mem_wait;
      default:
        state_next = mem_wait;
    endcase
  end

  // request goes out the cycle after enable, held until release
  assign mem_request_next = ((state == mem_wait) && op.op_enable) ||
                            (state == mem_request_state) ||
                            (state == mem_granted_state) ||
                            (state == op_run);
  assign mem_released_next = ((state == mem_wait) && !op.op_enable) ||
                             (state == mem_release) ||
                             (state == op_complete);

  assign set_run  = (state == op_run);
  assign clear_op = (state == mem_wait);

  // ----------------------------------------
  // state, flags and sync register
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state             <= mem_wait;
      mem_request       <= 1'b0;
      mem_released      <= 1'b1;
      ready             <= 1'b0;
      complete          <= 1'b0;
      op.strm_enable    <= 1'b0;
      this_synchronized <= 1'b0;
    end
    else
    begin
      state        <= state_next;
      mem_request  <= mem_request_next;
      mem_released <= mem_released_next;
      if (clear_op)
      begin
        ready          <= 1'b0;
        op.strm_enable <= 1'b0;
        complete       <= 1'b0;
      end
      else
      begin
        if (set_run)
        begin
          ready          <= 1'b1;
          op.strm_enable <= 1'b1;
        end
        if (state == op_complete)
          complete <= 1'b1;
      end
      // only meaningful while the lanes are running
      this_synchronized <= op.strm_enable && lanes_synced;
    end
  end

endmodule

// File: source/lane_stream_ctrl.sv
`timescale 1ns/100ps

module lane_stream_ctrl #(
  parameter int lane_index = 0
) (
  input  logic                                                   clk,
  input  logic                                                   reset,
  stream_op_if.lane                                              op,
  input  stream_ops_pkg::pe_id_t                                 pe_id,
  input  logic                                                   all_synchronized,
  input  stream_ops_pkg::pe_id_t [stream_ops_pkg::streams_per_lane-1:0] read_pe_id,
  input  logic [stream_ops_pkg::streams_per_lane-1:0]            dma_read_complete,
  input  logic [stream_ops_pkg::streams_per_lane-1:0]            dma_write_complete,
  input  logic [stream_ops_pkg::streams_per_lane-1:0]            stop_ready,
  input  logic [stream_ops_pkg::streams_per_lane-1:0]            stop_complete,
  output logic [stream_ops_pkg::streams_per_lane-1:0]            dma_read_enable,
  output logic [stream_ops_pkg::streams_per_lane-1:0]            dma_write_enable,
  output logic [stream_ops_pkg::streams_per_lane-1:0]            stop_enable,
  output stream_ops_pkg::stream_code_t [stream_ops_pkg::streams_per_lane-1:0] stop_source,
  output stream_ops_pkg::stream_code_t [stream_ops_pkg::streams_per_lane-1:0] stop_dest
);
  import stream_ops_pkg::*;

  typedef logic [streams_per_lane-1:0] strm_mask_t;

  lane_state_t state;
  lane_state_t state_next;

  logic       lane_on;
  strm_mask_t src_mask;
  strm_mask_t write_mask;
  strm_mask_t read_mask;
  strm_mask_t read_local;
  logic       stop_all_ready;
  logic       units_done;
  logic       clear_dma;

  // mask of the lowest count streams
  function automatic strm_mask_t first_streams(input stream_count_t count);
    strm_mask_t mask;
    for (int s = 0; s < streams_per_lane; s++)
    begin
      mask[s] = (count > s);
    end
    return mask;
  endfunction

  assign lane_on = op.lane_active[lane_index];

  // local DMA read only when source PE is this PE
  always_comb
  begin
    for (int s = 0; s < streams_per_lane; s++)
    begin
      read_local[s] = (read_pe_id[s] == pe_id);
    end
  end

  assign src_mask   = first_streams(op.src_count);
  assign write_mask = first_streams(op.to_memory_count) & first_streams(op.dest_count);
  assign read_mask  = first_streams(op.from_memory_count) & src_mask & read_local;

  // readiness from requested stream count, not from enable flags
  assign stop_all_ready = ((stop_ready & src_mask) == src_mask);

  // every enabled unit has reported complete
  assign units_done = ((dma_read_enable & ~dma_read_complete) == '0) &&
                      ((dma_write_enable & ~dma_write_complete) == '0) &&
                      ((stop_enable & ~stop_complete) == '0);

  // ----------------------------------------
  // lane FSM
  // ----------------------------------------
  always_comb
  begin
    state_next = state;
    case (state)
      lane_wait:
        if (op.strm_enable && op.op_enable && lane_on)
          state_next = lane_dma_write;
      lane_dma_write:
        state_next = lane_enable_stop;
      lane_enable_stop:
        if (stop_all_ready)
          state_next = lane_dma_read;
      lane_dma_read:
        state_next = lane_run;
      lane_run:
        if (units_done)
          state_next = lane_wait_sync;
      lane_wait_sync:
        if (all_synchronized)
          state_next = lane_complete;
      lane_complete:
        state_next = lane_complete;
      default:
        state_next = lane_wait;
    endcase
    // memory gone, abandon the lane
    if (!op.strm_enable)
      state_next = lane_wait;
  end

  assign clear_dma = (state == lane_complete) || (state == lane_wait);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state            <= lane_wait;
      dma_write_enable <= '0;
      dma_read_enable  <= '0;
      stop_enable      <= '0;
    end
    else
    begin
      state <= state_next;
      if (state == lane_dma_write)
        dma_write_enable <= write_mask;
      else if (clear_dma)
        dma_write_enable <= '0;
      if (state == lane_dma_read)
        dma_read_enable <= read_mask;
      else if (clear_dma)
        dma_read_enable <= '0;
      if (state == lane_enable_stop)
        stop_enable <= src_mask;
      else if (state == lane_wait)
        stop_enable <= '0;
    end
  end

  // stOp routing, captured with the write enables
  always_ff @(posedge clk)
  begin
    if (state == lane_dma_write)
    begin
      stop_source <= op.stream_source;
      stop_dest   <= op.stream_dest;
    end
  end

  // ----------------------------------------
  // status back to the sequencer
  // ----------------------------------------
  assign op.lane_synced[lane_index] = !lane_on ||
                                      (state == lane_wait_sync) || (state == lane_complete);
  assign op.lane_done[lane_index]   = !lane_on || (state == lane_complete);

endmodule

// File: source/stream_ops_cntl.sv
`timescale 1ns/100ps

module stream_ops_cntl (
  input  logic                   clk,
  input  logic                   reset,
  input  stream_ops_pkg::pe_id_t pe_id,
  input  stream_ops_pkg::op_word_t rs0,
  input  stream_ops_pkg::op_word_t rs1,
  input  logic                   all_synchronized,
  input  logic                   mem_granted,
  // per lane, per stream
  input  stream_ops_pkg::pe_id_t [stream_ops_pkg::num_lanes-1:0]
                                 [stream_ops_pkg::streams_per_lane-1:0] read_pe_id,
  input  logic [stream_ops_pkg::num_lanes-1:0][stream_ops_pkg::streams_per_lane-1:0]
                                 dma_read_complete,
  input  logic [stream_ops_pkg::num_lanes-1:0][stream_ops_pkg::streams_per_lane-1:0]
                                 dma_write_complete,
  input  logic [stream_ops_pkg::num_lanes-1:0][stream_ops_pkg::streams_per_lane-1:0]
                                 stop_ready,
  input  logic [stream_ops_pkg::num_lanes-1:0][stream_ops_pkg::streams_per_lane-1:0]
                                 stop_complete,
  output logic                   ready,
  output logic                   complete,
  output logic                   this_synchronized,
  output logic                   mem_request,
  output logic                   mem_released,
  output logic [stream_ops_pkg::num_lanes-1:0][stream_ops_pkg::streams_per_lane-1:0]
                                 dma_read_enable,
  output logic [stream_ops_pkg::num_lanes-1:0][stream_ops_pkg::streams_per_lane-1:0]
                                 dma_write_enable,
  output logic [stream_ops_pkg::num_lanes-1:0][stream_ops_pkg::streams_per_lane-1:0]
                                 stop_enable,
  output stream_ops_pkg::stream_code_t [stream_ops_pkg::num_lanes-1:0]
                                 [stream_ops_pkg::streams_per_lane-1:0] stop_source,
  output stream_ops_pkg::stream_code_t [stream_ops_pkg::num_lanes-1:0]
                                 [stream_ops_pkg::streams_per_lane-1:0] stop_dest
);
  import stream_ops_pkg::*;

  stream_op_if op_bus ();

  // ----------------------------------------
  // decode and memory sequencing
  // ----------------------------------------
  op_decode i_op_decode (
    .rs0 (rs0),
    .rs1 (rs1),
    .op  (op_bus.decoder)
  );

  mem_sequencer i_mem_sequencer (
    .clk               (clk),
    .reset             (reset),
    .op                (op_bus.sequencer),
    .mem_granted       (mem_granted),
    .mem_request       (mem_request),
    .mem_released      (mem_released),
    .ready             (ready),
    .complete          (complete),
    .this_synchronized (this_synchronized)
  );

  // one stream controller per exec lane
  for (genvar lane_num = 0; lane_num < num_lanes; lane_num++)
  begin : g_lane
    lane_stream_ctrl #(
      .lane_index (lane_num)
    ) i_lane_stream_ctrl (
      .clk                (clk),
      .reset              (reset),
      .op                 (op_bus.lane),
      .pe_id              (pe_id),
      .all_synchronized   (all_synchronized),
      .read_pe_id         (read_pe_id[lane_num]),
      .dma_read_complete  (dma_read_complete[lane_num]),
      .dma_write_complete (dma_write_complete[lane_num]),
      .stop_ready         (stop_ready[lane_num]),
      .stop_complete      (stop_complete[lane_num]),
      .dma_read_enable    (dma_read_enable[lane_num]),
      .dma_write_enable   (dma_write_enable[lane_num]),
      .stop_enable        (stop_enable[lane_num]),
      .stop_source        (stop_source[lane_num]),
      .stop_dest          (stop_dest[lane_num])
    );
  end

endmodule

// File: tests/stream_ops_cntl_properties.sv
`timescale 1ns/100ps

module stream_ops_cntl_properties (
  input logic                       clk,
  input logic                       reset,
  input stream_ops_pkg::mem_state_t seq_state,
  input logic                       ready,
  input logic                       complete,
  input logic                       mem_granted,
  input logic [stream_ops_pkg::num_lanes-1:0][stream_ops_pkg::streams_per_lane-1:0]
                                    dma_read_enable,
  input logic [stream_ops_pkg::num_lanes-1:0][stream_ops_pkg::streams_per_lane-1:0]
                                    stop_enable
);
  import stream_ops_pkg::*;

  // local read only behind an enabled stOp unit
  read_needs_stop: assert property (@(posedge clk) disable iff (reset)
    (dma_read_enable & ~stop_enable) == '0)
    else $error("dma read enable without its stop enable");

  // ready only from op_run on, lingering one cycle into mem_wait
  ready_only_after_run: assert property (@(posedge clk) disable iff (reset)
    ready |-> (seq_state inside {op_run, mem_release, op_complete}) ||
              ($past(seq_state) == op_complete))
    else $error("ready high while the sequencer waits for memory");

  // memory handed back before the operation reports complete
  complete_after_grant_gone: assert property (@(posedge clk) disable iff (reset)
    $rose(complete) |-> !$past(mem_granted, 2))
    else $error("complete raised while memory was still granted");

endmodule

bind stream_ops_cntl stream_ops_cntl_properties i_stream_ops_cntl_properties (
  .clk             (clk),
  .reset           (reset),
  .seq_state       (i_mem_sequencer.state),
  .ready           (ready),
  .complete        (complete),
  .mem_granted     (mem_granted),
  .dma_read_enable (dma_read_enable),
  .stop_enable     (stop_enable)
);

// File: tests/stream_ops_cntl_tb.sv
`timescale 1ns/100ps

module stream_ops_cntl_tb;
  import stream_ops_pkg::*;

  localparam int wait_limit   = 300;
  localparam int sel_request  = 0;
  localparam int sel_ready    = 1;
  localparam int sel_synced   = 2;
  localparam int sel_complete = 3;
  localparam int sel_idle     = 4;

  typedef logic [num_lanes-1:0][streams_per_lane-1:0] lane_bits_t;

  // ----------------------------------------
  // DUT inputs, all start low except reset
  // ----------------------------------------
  logic                                          clk = 1'b0;
  logic                                          reset = 1'b1;
  pe_id_t                                        pe_id = '0;
  op_word_t                                      rs0 = '0;
  op_word_t                                      rs1 = '0;
  logic                                          all_synchronized = 1'b0;
  logic                                          mem_granted = 1'b0;
  pe_id_t [num_lanes-1:0][streams_per_lane-1:0]  read_pe_id = '0;
  lane_bits_t                                    dma_read_complete = '0;
  lane_bits_t                                    dma_write_complete = '0;
  lane_bits_t                                    stop_ready = '0;
  lane_bits_t                                    stop_complete = '0;

  logic                                          ready;
  logic                                          complete;
  logic                                          this_synchronized;
  logic                                          mem_request;
  logic                                          mem_released;
  lane_bits_t                                    dma_read_enable;
  lane_bits_t                                    dma_write_enable;
  lane_bits_t                                    stop_enable;
  stream_code_t [num_lanes-1:0][streams_per_lane-1:0] stop_source;
  stream_code_t [num_lanes-1:0][streams_per_lane-1:0] stop_dest;

  // response model delays
  logic [7:0] lfsr_state = 8'd57;
  int         grant_delay = 0;
  int         sync_delay = 0;
  int         ready_delay [num_lanes][streams_per_lane];
  int         done_delay [num_lanes][streams_per_lane];
  int         read_delay [num_lanes][streams_per_lane];
  int         write_delay [num_lanes][streams_per_lane];

  // monitor state, cleared whenever the controller is idle
  logic       grant_seen = 1'b0;
  logic       sync_given = 1'b0;
  lane_bits_t seen_write = '0;
  lane_bits_t seen_stop = '0;
  lane_bits_t seen_read = '0;
  int         errors = 0;
  int         timeouts = 0;

  stream_ops_cntl i_stream_ops_cntl (
    .clk                (clk),
    .reset              (reset),
    .pe_id              (pe_id),
    .rs0                (rs0),
    .rs1                (rs1),
    .all_synchronized   (all_synchronized),
    .mem_granted        (mem_granted),
    .read_pe_id         (read_pe_id),
    .dma_read_complete  (dma_read_complete),
    .dma_write_complete (dma_write_complete),
    .stop_ready         (stop_ready),
    .stop_complete      (stop_complete),
    .ready              (ready),
    .complete           (complete),
    .this_synchronized  (this_synchronized),
    .mem_request        (mem_request),
    .mem_released       (mem_released),
    .dma_read_enable    (dma_read_enable),
    .dma_write_enable   (dma_write_enable),
    .stop_enable        (stop_enable),
    .stop_source        (stop_source),
    .stop_dest          (stop_dest)
  );

  always #50 clk = ~clk;

  // galois lfsr, x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] state);
    return state[0] ? ((state >> 1) ^ 8'hb8) : (state >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic random_bits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  // response follows its enable after a random number of cycles
  task automatic respond(input logic enable, input logic current, input int bits,
                         inout int delay, output logic next);
    if (!enable)
    begin
      next = 1'b0;
      random_bits(bits, delay);
    end
    else if (current || delay == 0)
      next = 1'b1;
    else
    begin
      next  = 1'b0;
      delay = delay - 1;
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  function automatic logic watch(input int sel);
    case (sel)
      sel_request:  return mem_request;
      sel_ready:    return ready;
      sel_synced:   return this_synchronized;
      sel_complete: return complete;
      default:      return !ready && !complete && !this_synchronized && !mem_request &&
                           mem_released && dma_read_enable == '0 &&
                           dma_write_enable == '0 && stop_enable == '0;
    endcase
  endfunction

  task automatic wait_until(input string what, input int sel);
    int cycles;
    cycles = 0;
    while (!watch(sel) && cycles < wait_limit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!watch(sel))
    begin
      $display("timeout: %s did not happen within %0d cycles", what, wait_limit);
      timeouts++;
    end
  endtask

  task automatic check_idle(input string tag);
    check_value({tag, " mem_request"}, 1'b0, mem_request);
    check_value({tag, " mem_released"}, 1'b1, mem_released);
    check_value({tag, " ready"}, 1'b0, ready);
    check_value({tag, " complete"}, 1'b0, complete);
    check_value({tag, " this_synchronized"}, 1'b0, this_synchronized);
    check_value({tag, " dma_read_enable"}, '0, dma_read_enable);
    check_value({tag, " dma_write_enable"}, '0, dma_write_enable);
    check_value({tag, " stop_enable"}, '0, stop_enable);
  endtask

  // ----------------------------------------
  // environment model: grant, sync, units
  // ----------------------------------------
  always @(posedge clk)
  begin
    logic next;
    respond(mem_request, mem_granted, 2, grant_delay, next);
    mem_granted <= next;
    // a few cycles for the other PEs to catch up
    respond(this_synchronized, all_synchronized, 3, sync_delay, next);
    all_synchronized <= next;
    for (int l = 0; l < num_lanes; l++)
    begin
      for (int s = 0; s < streams_per_lane; s++)
      begin
        respond(stop_enable[l][s], stop_ready[l][s], 2, ready_delay[l][s], next);
        stop_ready[l][s] <= next;
        respond(stop_enable[l][s], stop_complete[l][s], 3, done_delay[l][s], next);
        stop_complete[l][s] <= next;
        respond(dma_read_enable[l][s], dma_read_complete[l][s], 3, read_delay[l][s], next);
        dma_read_complete[l][s] <= next;
        respond(dma_write_enable[l][s], dma_write_complete[l][s], 3, write_delay[l][s], next);
        dma_write_complete[l][s] <= next;
      end
    end
  end

  // ----------------------------------------
  // ordering checks every cycle
  // ----------------------------------------
  always @(negedge clk)
  begin
    lane_bits_t pending;
    // enabled units still busy
    pending = (dma_read_enable & ~dma_read_complete) |
              (dma_write_enable & ~dma_write_complete) |
              (stop_enable & ~stop_complete);
    if (reset || (mem_released && !mem_request && !ready && !complete))
    begin
      grant_seen = 1'b0;
      sync_given = 1'b0;
      seen_write = '0;
      seen_stop  = '0;
      seen_read  = '0;
    end
    else
    begin
      grant_seen = grant_seen | mem_granted;
      sync_given = sync_given | all_synchronized;
      if (ready)
      begin
        seen_write = seen_write | dma_write_enable;
        seen_stop  = seen_stop | stop_enable;
        seen_read  = seen_read | dma_read_enable;
      end
    end
    if (!reset)
    begin
      check_value("ready before grant", 1'b0, ready & ~grant_seen);
      check_value("sync before units done", '0, this_synchronized ? pending : lane_bits_t'(0));
      check_value("complete before all_synchronized", 1'b0, complete & ~sync_given);
    end
  end

  task automatic run_operation(input int num, input op_word_t op_rs0, input op_word_t op_rs1,
                               input pe_id_t op_pe, input logic [47:0] op_read,
                               input lane_bits_t exp_write, input lane_bits_t exp_stop,
                               input lane_bits_t exp_read);
    string tag;
    tag = $sformatf("op %0d", num);
    @(posedge clk);
    rs0        <= op_rs0;
    rs1        <= op_rs1;
    pe_id      <= op_pe;
    read_pe_id <= op_read;
    wait_until({tag, " mem_request"}, sel_request);
    check_value({tag, " mem_released at request"}, 1'b0, mem_released);
    wait_until({tag, " ready"}, sel_ready);
    wait_until({tag, " this_synchronized"}, sel_synced);
    wait_until({tag, " complete"}, sel_complete);
    check_value({tag, " mem_request at complete"}, 1'b0, mem_request);
    check_value({tag, " mem_released at complete"}, 1'b1, mem_released);
    check_value({tag, " dma_write_enable mask"}, exp_write, seen_write);
    check_value({tag, " stop_enable mask"}, exp_stop, seen_stop);
    check_value({tag, " dma_read_enable mask"}, exp_read, seen_read);
    // both stream codes sit next to each other in rs0
    for (int l = 0; l < num_lanes; l++)
    begin
      if (op_rs1[l])
      begin
        check_value($sformatf("%s lane %0d stop_source", tag, l),
                    op_rs0[strm0_src_lsb +: 4], stop_source[l]);
        check_value($sformatf("%s lane %0d stop_dest", tag, l),
                    op_rs0[strm0_dest_lsb +: 4], stop_dest[l]);
      end
    end
    @(posedge clk);
    rs0[enable_bit] <= 1'b0;
    wait_until({tag, " return to idle"}, sel_idle);
    check_idle({tag, " after enable drop"});
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial
  begin
    int          fd;
    int          fields;
    int          op_count;
    string       line;
    op_word_t    op_rs0;
    op_word_t    op_rs1;
    pe_id_t      op_pe;
    logic [47:0] op_read;
    lane_bits_t  exp_write;
    lane_bits_t  exp_stop;
    lane_bits_t  exp_read;
    op_count = 0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_idle("after reset");
    fd = $fopen("tests/stream_ops_cntl_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the stimulus file");
      errors++;
    end
    else
    begin
      // stop reading once anything has hung
      while (!$feof(fd) && timeouts == 0)
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line[0] == "#")
          continue;
        fields = $sscanf(line, "%h %h %h %h %h %h %h", op_rs0, op_rs1, op_pe, op_read,
                         exp_write, exp_stop, exp_read);
        if (fields != 7)
        begin
          $display("stimulus line could not be read: %s", line);
          errors++;
        end
        else
        begin
          op_count++;
          run_operation(op_count, op_rs0, op_rs1, op_pe, op_read, exp_write, exp_stop,
                        exp_read);
        end
      end
      $fclose(fd);
    end
    if (op_count == 0)
    begin
      $display("no operation was run");
      errors++;
    end
    $display("%0d operations, %0d errors, %0d timeouts", op_count, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// File: tests/stream_ops_cntl_stimulus.txt
# columns, all hex: rs0 rs1 pe_id read_pe_id dma_write_mask stop_mask dma_read_mask
# read_pe_id packs lane 3 down to lane 0, stream 1 above stream 0, 6 bits per id
# each mask packs lane 3 down to lane 0, stream 1 above stream 0
#
# two memory sources, one memory destination, lanes 0 and 2, lane 2 stream 1 remote
000012ad 00000005 0a 28a0ca28a28a 11 33 13
# one memory source, two memory destinations, all lanes, lane 1 source remote
00000b33 0000000f 15 555555547555 ff 55 51
# enable only, no streams, lane 1
00000001 00000002 00 000000000000 00 00 00
# one stream each way on lane 3, source on a remote PE
0000022b 00000008 3f fc1fffffffff 40 40 00

// File: all.f
source/stream_ops_pkg.sv
source/stream_op_if.sv
source/op_decode.sv
source/mem_sequencer.sv
source/lane_stream_ctrl.sv
source/stream_ops_cntl.sv
tests/stream_ops_cntl_properties.sv
tests/stream_ops_cntl_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module stream_ops_cntl_tb -f all.f -o stream_ops_cntl_sim

./obj_dir/stream_ops_cntl_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
